//--- design/soc_ifc_pkg.sv
// Shared boot types and APB offsets that assume all fuse words sit below offset 0x100
package soc_ifc_pkg;

    // Boot state encoding, also visible in bits 2:0 of the status register
    typedef enum logic [2:0] {
        BOOT_IDLE   = 3'b000,
        BOOT_FUSE   = 3'b001,
        BOOT_FW_RST = 3'b010,
        BOOT_WAIT   = 3'b011,
        BOOT_DONE   = 3'b100
    } boot_fsm_state_e;

    // APB byte address and data word
    typedef logic [11:0] apb_addr_t;
    typedef logic [31:0] apb_data_t;

    // Length of the firmware-update wait in clock cycles
    typedef logic [7:0] wait_cnt_t;

    // Fuse words start at the base and take one 32-bit slot each
    localparam apb_addr_t REG_FUSE_BASE       = 12'h000;
    // Control and status registers above the fuse window
    localparam apb_addr_t REG_FUSE_WR_DONE    = 12'h100;
    localparam apb_addr_t REG_FW_UPDATE_RESET = 12'h104;
    localparam apb_addr_t REG_FW_UPDATE_WAIT  = 12'h108;
    localparam apb_addr_t REG_BOOTFSM_GO      = 12'h10C;
    localparam apb_addr_t REG_BOOT_STATUS     = 12'h110;

endpackage

//--- design/boot_ctrl_if.sv
// Control and status between the APB registers and the boot FSM with both pulses one clock wide
interface boot_ctrl_if;
    import soc_ifc_pkg::*;

    // Fuse programming handshake from the SoC
    logic            fuse_done;
    logic            fuse_wr_done_observed;
    // Firmware-update request pulse and its wait length
    logic            fw_update_rst;
    wait_cnt_t       fw_update_rst_wait_cycles;
    // Releases a breakpoint hold in WAIT
    logic            bootfsm_continue;

    // FSM status back to the register block
    logic            ready_for_fuses;
    boot_fsm_state_e boot_fsm_ps;
    // One-cycle pulse when an update reset starts
    logic            fw_upd_rst_executed;

    // Register side drives the requests and reads the status
    modport regs (
        output fuse_done,
        output fuse_wr_done_observed,
        output fw_update_rst,
        output fw_update_rst_wait_cycles,
        output bootfsm_continue,
        input  ready_for_fuses,
        input  boot_fsm_ps,
        input  fw_upd_rst_executed
    );

    // FSM side is the mirror image
    modport fsm (
        input  fuse_done,
        input  fuse_wr_done_observed,
        input  fw_update_rst,
        input  fw_update_rst_wait_cycles,
        input  bootfsm_continue,
        output ready_for_fuses,
        output boot_fsm_ps,
        output fw_upd_rst_executed
    );

endinterface

//--- design/soc_ifc_boot_fsm.sv
// Boot FSM with two-flop reset outputs and an RDC window of 3 cycles after cptra_rst_b
module soc_ifc_boot_fsm (
    input  logic     clk,
    input  logic     cptra_pwrgood,
    input  logic     cptra_rst_b,
    input  logic     bootfsm_brkpoint,
    boot_ctrl_if.fsm ctrl,
    output logic     cptra_noncore_rst_b,
    output logic     cptra_uc_rst_b,
    output logic     iccm_unlock,
    output logic     rdc_clk_dis,
    output logic     fw_update_rst_window
);
    import soc_ifc_pkg::*;

    // Present and next state
    boot_fsm_state_e boot_fsm_ps;
    boot_fsm_state_e boot_fsm_ns;

    // Transition conditions
    logic arc_idle_fuse;
    logic arc_fuse_done;
    logic arc_fuse_wait;
    logic arc_done_fwrst;
    logic arc_fwrst_wait;
    logic arc_wait_done;

    // Reset requests from the decoder and their first synchronizer stage
    logic fsm_noncore_rst_b;
    logic fsm_uc_rst_b;
    logic synch_noncore_rst_b;
    logic synch_uc_rst_b;

    logic fsm_iccm_unlock;
    logic ready_for_fuses;
    logic fw_upd_rst_executed;

    // Firmware-update wait timer
    wait_cnt_t wait_count;
    logic      wait_count_load;
    logic      wait_count_decr;

    // Three-stage window that follows the release of cptra_rst_b
    logic rst_window;
    logic rst_window_f;
    logic rst_window_ff;

    // Leave IDLE once the first window stage has dropped
    assign arc_idle_fuse = (boot_fsm_ps == BOOT_IDLE) && !rst_window;

    // Fuse_done alone is not enough after a warm reset
    // The SoC has to repeat the write so that the observed flag is set again
    assign arc_fuse_done = ctrl.fuse_done && ctrl.fuse_wr_done_observed;

    // A strapped breakpoint diverts the fuse exit into WAIT
    assign arc_fuse_wait = bootfsm_brkpoint;

    // Update request is only honoured once the core is running
    assign arc_done_fwrst = (boot_fsm_ps == BOOT_DONE) && ctrl.fw_update_rst;

    // Move on once the core reset output itself has been asserted
    assign arc_fwrst_wait = !cptra_uc_rst_b;

    // Exit WAIT when the timer is empty and no breakpoint holds the core
    assign arc_wait_done = (wait_count == '0) && !(bootfsm_brkpoint && !ctrl.bootfsm_continue);

    // Window for masking combinational paths out of the core reset flops
    assign fw_update_rst_window = (boot_fsm_ps == BOOT_FW_RST) || (boot_fsm_ps == BOOT_WAIT);

    // Clocks stay disabled while any window stage is set
    assign rdc_clk_dis = rst_window || rst_window_f || rst_window_ff;

    always_comb begin
        boot_fsm_ns         = boot_fsm_ps;
        ready_for_fuses     = 1'b0;
        fw_upd_rst_executed = 1'b0;
        fsm_noncore_rst_b   = 1'b0;
        fsm_uc_rst_b        = 1'b0;
        fsm_iccm_unlock     = 1'b0;
        wait_count_load     = 1'b0;
        wait_count_decr     = 1'b0;

        unique case (boot_fsm_ps)
            BOOT_IDLE: begin
                // Both resets stay asserted until the fuses are in
                if (arc_idle_fuse) begin
                    boot_fsm_ns = BOOT_FUSE;
                end
            end
            BOOT_FUSE: begin
                ready_for_fuses = 1'b1;
                if (arc_fuse_done) begin
                    if (arc_fuse_wait) begin
                        boot_fsm_ns = BOOT_WAIT;
                    end else begin
                        boot_fsm_ns = BOOT_DONE;
                    end
                end
            end
            BOOT_FW_RST: begin
                // Core goes into reset while the rest of the SoC keeps running
                fsm_noncore_rst_b = 1'b1;
                // Timer takes the programmed length here
                wait_count_load   = 1'b1;
                if (arc_fwrst_wait) begin
                    boot_fsm_ns = BOOT_WAIT;
                end
            end
            BOOT_WAIT: begin
                fsm_noncore_rst_b = 1'b1;
                wait_count_decr   = 1'b1;
                // ICCM opens only at the end of the flow so that no early
                // write can race the new firmware
                if (arc_wait_done) begin
                    boot_fsm_ns     = BOOT_DONE;
                    fsm_iccm_unlock = 1'b1;
                end
            end
            BOOT_DONE: begin
                fsm_noncore_rst_b = 1'b1;
                fsm_uc_rst_b      = 1'b1;
                if (arc_done_fwrst) begin
                    boot_fsm_ns         = BOOT_FW_RST;
                    // Reported once per update so the registers can keep it sticky
                    fw_upd_rst_executed = 1'b1;
                end
            end
            default: begin
                // Unused encodings fall back to IDLE
                boot_fsm_ns = BOOT_IDLE;
            end
        endcase
    end

    // State and reset synchronizers live in the power-good domain
    // They must keep running while cptra_rst_b is held low
    always_ff @(posedge clk or negedge cptra_pwrgood) begin
        if (!cptra_pwrgood) begin
            boot_fsm_ps         <= BOOT_IDLE;
            synch_noncore_rst_b <= 1'b0;
            synch_uc_rst_b      <= 1'b0;
            cptra_noncore_rst_b <= 1'b0;
            cptra_uc_rst_b      <= 1'b0;
        end else begin
            // Warm reset forces IDLE through the window
            boot_fsm_ps         <= rst_window ? BOOT_IDLE : boot_fsm_ns;
            synch_noncore_rst_b <= fsm_noncore_rst_b;
            synch_uc_rst_b      <= fsm_uc_rst_b;
            cptra_noncore_rst_b <= synch_noncore_rst_b;
            // Core leaves reset only when both requests are released
            cptra_uc_rst_b      <= synch_noncore_rst_b && synch_uc_rst_b;
        end
    end

    // Window, timer and unlock flop are cleared by every warm reset
    always_ff @(posedge clk or negedge cptra_rst_b) begin
        if (!cptra_rst_b) begin
            rst_window    <= 1'b1;
            rst_window_f  <= 1'b1;
            rst_window_ff <= 1'b1;
            wait_count    <= '0;
            iccm_unlock   <= 1'b0;
        end else begin
            rst_window    <= 1'b0;
            rst_window_f  <= rst_window;
            rst_window_ff <= rst_window_f;
            // Count down to zero and hold there
            if (wait_count_decr && (wait_count != '0)) begin
                wait_count <= wait_count - 1'b1;
            end else if (wait_count_load) begin
                wait_count <= ctrl.fw_update_rst_wait_cycles;
            end
            iccm_unlock <= fsm_iccm_unlock;
        end
    end

    // Status back to the registers
    assign ctrl.boot_fsm_ps         = boot_fsm_ps;
    assign ctrl.ready_for_fuses     = ready_for_fuses;
    assign ctrl.fw_upd_rst_executed = fw_upd_rst_executed;

endmodule

//--- design/soc_ifc_apb_regs.sv
// Zero-wait APB slave for the boot registers that supports up to 64 fuse words
module soc_ifc_apb_regs #(
    parameter int FUSE_WORDS = 8
) (
    input  logic                  clk,
    input  logic                  cptra_pwrgood,
    input  logic                  cptra_rst_b,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  soc_ifc_pkg::apb_addr_t paddr,
    input  soc_ifc_pkg::apb_data_t pwdata,
    output soc_ifc_pkg::apb_data_t prdata,
    output logic                  pslverr,
    boot_ctrl_if.regs             ctrl
);
    import soc_ifc_pkg::*;

    // Index width stays at least one bit for a single fuse word
    localparam int FUSE_IDX_W = (FUSE_WORDS > 1) ? $clog2(FUSE_WORDS) : 1;

    // Fuse storage has no reset and is loaded by the SoC
    apb_data_t fuse_mem [0:FUSE_WORDS-1];

    apb_addr_t               fuse_off;
    logic [FUSE_IDX_W-1:0]   fuse_idx;

    // Address decode
    logic hit_fuse;
    logic hit_done;
    logic hit_fw_upd;
    logic hit_wait;
    logic hit_go;
    logic hit_status;
    logic unmapped;

    logic access;
    logic wr;
    logic fuse_we;

    // Register state
    logic      fuse_done;
    logic      fuse_wr_done_observed;
    logic      fw_update_rst;
    wait_cnt_t wait_cycles;
    logic      bootfsm_continue;
    logic      fw_upd_rst_sticky;
    apb_data_t status_word;

    // Fuse window is word aligned and sized by the parameter
    assign fuse_off = paddr - REG_FUSE_BASE;
    assign fuse_idx = fuse_off[FUSE_IDX_W+1:2];
    assign hit_fuse = (paddr >= REG_FUSE_BASE) && (fuse_off[1:0] == 2'b00)
                   && (fuse_off[11:2] < 10'(FUSE_WORDS));

    assign hit_done   = (paddr == REG_FUSE_WR_DONE);
    assign hit_fw_upd = (paddr == REG_FW_UPDATE_RESET);
    assign hit_wait   = (paddr == REG_FW_UPDATE_WAIT);
    assign hit_go     = (paddr == REG_BOOTFSM_GO);
    assign hit_status = (paddr == REG_BOOT_STATUS);
    assign unmapped   = !(hit_fuse || hit_done || hit_fw_upd || hit_wait || hit_go || hit_status);

    // Every transfer finishes in its access phase
    assign access = psel && penable;
    assign wr     = access && pwrite;

    // Fuses lock for good once the SoC has signalled completion
    assign fuse_we = wr && hit_fuse && !fuse_done;

    always_ff @(posedge clk) begin
        if (fuse_we) begin
            fuse_mem[fuse_idx] <= pwdata;
        end
    end

    // Flags that must survive a warm reset
    always_ff @(posedge clk or negedge cptra_pwrgood) begin
        if (!cptra_pwrgood) begin
            fuse_done         <= 1'b0;
            fw_upd_rst_sticky <= 1'b0;
        end else begin
            if (wr && hit_done && pwdata[0]) begin
                fuse_done <= 1'b1;
            end
            // Remembers that at least one update reset has run
            if (ctrl.fw_upd_rst_executed) begin
                fw_upd_rst_sticky <= 1'b1;
            end
        end
    end

    // Flags that a warm reset clears
    always_ff @(posedge clk or negedge cptra_rst_b) begin
        if (!cptra_rst_b) begin
            fuse_wr_done_observed <= 1'b0;
            fw_update_rst         <= 1'b0;
            wait_cycles           <= '0;
            bootfsm_continue      <= 1'b0;
        end else begin
            // The done write is accepted again after a warm reset
            if (wr && hit_done && pwdata[0]) begin
                fuse_wr_done_observed <= 1'b1;
            end
            // Request lasts exactly one clock
            fw_update_rst <= wr && hit_fw_upd && pwdata[0];
            if (wr && hit_wait) begin
                wait_cycles <= pwdata[7:0];
            end
            if (wr && hit_go && pwdata[0]) begin
                bootfsm_continue <= 1'b1;
            end
        end
    end

    // Status layout is state, fuse readiness and the sticky update flag
    assign status_word = {27'b0, fw_upd_rst_sticky, ctrl.ready_for_fuses, ctrl.boot_fsm_ps};

    // Read data is valid throughout the access phase
    always_comb begin
        prdata = '0;
        if (hit_fuse) begin
            prdata = fuse_mem[fuse_idx];
        end else if (hit_done) begin
            prdata = {31'b0, fuse_done};
        end else if (hit_wait) begin
            prdata = {24'b0, wait_cycles};
        end else if (hit_go) begin
            prdata = {31'b0, bootfsm_continue};
        end else if (hit_status) begin
            prdata = status_word;
        end
        // The update request bit always reads back as zero
    end

    // Errors for holes in the map, locked fuses and the read-only status
    assign pslverr = access && (unmapped
                             || (pwrite && hit_fuse && fuse_done)
                             || (pwrite && hit_status));

    // Requests towards the FSM
    assign ctrl.fuse_done                 = fuse_done;
    assign ctrl.fuse_wr_done_observed     = fuse_wr_done_observed;
    assign ctrl.fw_update_rst             = fw_update_rst;
    assign ctrl.fw_update_rst_wait_cycles = wait_cycles;
    assign ctrl.bootfsm_continue          = bootfsm_continue;

endmodule

//--- design/soc_ifc_top.sv
// Boot block top whose APB slave never stalls so no pready is provided
module soc_ifc_top #(
    parameter int FUSE_WORDS = 8
) (
    input  logic                   clk,
    input  logic                   cptra_pwrgood,
    input  logic                   cptra_rst_b,

    // APB slave
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  soc_ifc_pkg::apb_addr_t paddr,
    input  soc_ifc_pkg::apb_data_t pwdata,
    output soc_ifc_pkg::apb_data_t prdata,
    output logic                   pslverr,

    // Strap that holds the core in WAIT after fuse programming
    input  logic                   bootfsm_brkpoint,

    // Reset and control outputs to the rest of the SoC
    output logic                   cptra_noncore_rst_b,
    output logic                   cptra_uc_rst_b,
    output logic                   iccm_unlock,
    output logic                   rdc_clk_dis,
    output logic                   fw_update_rst_window
);

    // Control and status bundle between the registers and the FSM
    boot_ctrl_if ctrl_if_i ();

    // Register block sized by the fuse count
    soc_ifc_apb_regs #(
        .FUSE_WORDS (FUSE_WORDS)
    ) apb_regs_i (
        .clk           (clk),
        .cptra_pwrgood (cptra_pwrgood),
        .cptra_rst_b   (cptra_rst_b),
        .psel          (psel),
        .penable       (penable),
        .pwrite        (pwrite),
        .paddr         (paddr),
        .pwdata        (pwdata),
        .prdata        (prdata),
        .pslverr       (pslverr),
        .ctrl          (ctrl_if_i.regs)
    );

    // Sequencer for cold, warm and firmware-update resets
    soc_ifc_boot_fsm boot_fsm_i (
        .clk                  (clk),
        .cptra_pwrgood        (cptra_pwrgood),
        .cptra_rst_b          (cptra_rst_b),
        .bootfsm_brkpoint     (bootfsm_brkpoint),
        .ctrl                 (ctrl_if_i.fsm),
        .cptra_noncore_rst_b  (cptra_noncore_rst_b),
        .cptra_uc_rst_b       (cptra_uc_rst_b),
        .iccm_unlock          (iccm_unlock),
        .rdc_clk_dis          (rdc_clk_dis),
        .fw_update_rst_window (fw_update_rst_window)
    );

endmodule

//--- verif/soc_ifc_tb_clk.sv
// Free-running testbench clock that starts low with the first rising edge at half a period
module soc_ifc_tb_clk #(
    parameter int PERIOD = 4
) (
    output logic clk
);

    // Toggle every half period for the whole run
    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2);
            clk = ~clk;
        end
    end

endmodule

//--- verif/soc_ifc_tb.sv
// Testbench for soc_ifc_top that assumes FUSE_WORDS below 64 and stops at the first failure
module soc_ifc_tb;
    import soc_ifc_pkg::*;

    localparam int FUSE_WORDS  = 8;
    localparam int TIMEOUT     = 50;
    // Selectors for the outputs that the generic wait can watch
    localparam int SIG_NONCORE = 0;
    localparam int SIG_UC      = 1;
    localparam int SIG_RDC     = 2;

    logic clk;
    logic cptra_pwrgood;
    logic cptra_rst_b;
    logic psel;
    logic penable;
    logic pwrite;
    apb_addr_t paddr;
    apb_data_t pwdata;
    apb_data_t prdata;
    logic pslverr;
    logic bootfsm_brkpoint;
    logic cptra_noncore_rst_b;
    logic cptra_uc_rst_b;
    logic iccm_unlock;
    logic rdc_clk_dis;
    logic fw_update_rst_window;

    // Reference model of the fuse array and the sticky update flag
    apb_data_t model_fuse [0:FUSE_WORDS-1];
    logic      model_executed;
    logic [15:0] lfsr_state;
    int          error_count;

    soc_ifc_tb_clk #(.PERIOD(4)) clk_gen_i (.clk(clk));

    soc_ifc_top #(
        .FUSE_WORDS (FUSE_WORDS)
    ) soc_ifc_top_i (
        .clk                  (clk),
        .cptra_pwrgood        (cptra_pwrgood),
        .cptra_rst_b          (cptra_rst_b),
        .psel                 (psel),
        .penable              (penable),
        .pwrite               (pwrite),
        .paddr                (paddr),
        .pwdata               (pwdata),
        .prdata               (prdata),
        .pslverr              (pslverr),
        .bootfsm_brkpoint     (bootfsm_brkpoint),
        .cptra_noncore_rst_b  (cptra_noncore_rst_b),
        .cptra_uc_rst_b       (cptra_uc_rst_b),
        .iccm_unlock          (iccm_unlock),
        .rdc_clk_dis          (rdc_clk_dis),
        .fw_update_rst_window (fw_update_rst_window)
    );

    // 16-bit Fibonacci LFSR with taps 16, 14, 13 and 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // One LFSR step per bit, shifted in from the right
    task automatic random_bits(input int nbits, output apb_data_t value);
        value = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value      = {value[30:0], lfsr_state[0]};
        end
    endtask

    // Status layout taken from the register map: executed, ready, state
    function automatic apb_data_t expected_status(input boot_fsm_state_e st, input logic ready,
                                                  input logic executed);
        return {27'b0, executed, ready, st};
    endfunction

    task automatic abort_run();
        $display("tests failed");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic check_value(input string name, input apb_data_t expected,
                               input apb_data_t actual);
        if (expected !== actual) begin
            error_count++;
            $display("** Error %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
            abort_run();
        end
    endtask

    function automatic logic output_level(input int sel);
        case (sel)
            SIG_NONCORE: return cptra_noncore_rst_b;
            SIG_UC:      return cptra_uc_rst_b;
            default:     return rdc_clk_dis;
        endcase
    endfunction

    // Counts rising edges until the selected output reaches the level
    task automatic wait_level(input int sel, input logic level, input int limit,
                              input string what, output int cycles);
        cycles = 0;
        while (output_level(sel) !== level) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > limit) begin
                $display("Timeout: %s did not happen within %0d cycles", what, limit);
                abort_run();
            end
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    // Both APB tasks start and end 1 time unit after a rising edge
    // The access phase completes at the second edge
    task automatic apb_write(input apb_addr_t addr, input apb_data_t data, output logic err);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        idle_cycles(1);
        penable = 1'b1;
        #1;
        err = pslverr;
        idle_cycles(1);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic err);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        idle_cycles(1);
        penable = 1'b1;
        #1;
        data = prdata;
        err  = pslverr;
        idle_cycles(1);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    // Power-on reset for 8 cycles, which also clears the fuse lock
    task automatic power_on(input logic brk);
        idle_cycles(1);
        cptra_pwrgood    = 1'b0;
        cptra_rst_b      = 1'b0;
        bootfsm_brkpoint = brk;
        model_executed   = 1'b0;
        idle_cycles(8);
        cptra_pwrgood = 1'b1;
        cptra_rst_b   = 1'b1;
    endtask

    initial begin
        apb_data_t rdata;
        apb_data_t word;
        apb_data_t wait_val;
        logic      err;
        int        cycles;
        int        pulses;
        int        first_pulse;
        int        idx;
        logic      noncore_dropped;

        cptra_pwrgood    = 1'b0;
        cptra_rst_b      = 1'b0;
        psel             = 1'b0;
        penable          = 1'b0;
        pwrite           = 1'b0;
        paddr            = '0;
        pwdata           = '0;
        bootfsm_brkpoint = 1'b0;
        model_executed   = 1'b0;
        error_count      = 0;
        lfsr_state       = 16'd49057;

        // Cold boot
        power_on(1'b0);
        check_value("cold_boot rdc_clk_dis at release", 1, rdc_clk_dis);
        wait_level(SIG_RDC, 1'b0, TIMEOUT, "rdc_clk_dis release", cycles);
        check_value("cold_boot rdc_clk_dis cycles", 3, cycles);
        apb_read(REG_BOOT_STATUS, rdata, err);
        check_value("cold_boot status", expected_status(BOOT_FUSE, 1'b1, 1'b0), rdata);
        check_value("cold_boot noncore reset", 0, cptra_noncore_rst_b);
        check_value("cold_boot uc reset", 0, cptra_uc_rst_b);

        // Fuse programming with readback against the model
        for (idx = 0; idx < FUSE_WORDS; idx++) begin
            random_bits(32, word);
            model_fuse[idx] = word;
            apb_write(REG_FUSE_BASE + apb_addr_t'(4 * idx), word, err);
            check_value("fuse write pslverr", 0, err);
        end
        for (idx = 0; idx < FUSE_WORDS; idx++) begin
            apb_read(REG_FUSE_BASE + apb_addr_t'(4 * idx), rdata, err);
            check_value("fuse readback", model_fuse[idx], rdata);
        end
        apb_write(REG_FUSE_WR_DONE, 32'h1, err);
        wait_level(SIG_NONCORE, 1'b1, TIMEOUT, "noncore reset release", cycles);
        check_value("fuse_done noncore delay", 3, cycles);
        check_value("fuse_done uc released", 1, cptra_uc_rst_b);
        apb_read(REG_BOOT_STATUS, rdata, err);
        check_value("fuse_done status", expected_status(BOOT_DONE, 1'b0, 1'b0), rdata);
        random_bits(6, word);
        idx = int'(word) % FUSE_WORDS;
        random_bits(32, word);
        apb_write(REG_FUSE_BASE + apb_addr_t'(4 * idx), word, err);
        check_value("locked fuse write pslverr", 1, err);
        apb_read(REG_FUSE_BASE + apb_addr_t'(4 * idx), rdata, err);
        check_value("locked fuse unchanged", model_fuse[idx], rdata);

        // Breakpoint boot holds the core in WAIT until GO
        power_on(1'b1);
        wait_level(SIG_RDC, 1'b0, TIMEOUT, "rdc_clk_dis release", cycles);
        apb_write(REG_FUSE_WR_DONE, 32'h1, err);
        wait_level(SIG_NONCORE, 1'b1, TIMEOUT, "noncore reset release", cycles);
        check_value("breakpoint noncore delay", 3, cycles);
        check_value("breakpoint uc held", 0, cptra_uc_rst_b);
        apb_read(REG_BOOT_STATUS, rdata, err);
        check_value("breakpoint status", expected_status(BOOT_WAIT, 1'b0, 1'b0), rdata);
        apb_write(REG_BOOTFSM_GO, 32'h1, err);
        pulses      = 0;
        first_pulse = -1;
        cycles      = 0;
        while (!cptra_uc_rst_b) begin
            idle_cycles(1);
            cycles++;
            if (iccm_unlock) begin
                pulses++;
                if (first_pulse < 0) begin
                    first_pulse = cycles;
                end
            end
            if (cycles > TIMEOUT) begin
                $display("Timeout: uc reset was not released after the GO write");
                abort_run();
            end
        end
        check_value("breakpoint iccm_unlock pulses", 1, pulses);
        check_value("breakpoint unlock before uc", 1, (first_pulse > 0) && (first_pulse < cycles));

        // Firmware-update reset with a random wait length
        bootfsm_brkpoint = 1'b0;
        random_bits(8, wait_val);
        apb_write(REG_FW_UPDATE_WAIT, wait_val, err);
        apb_read(REG_FW_UPDATE_WAIT, rdata, err);
        check_value("fw_update wait readback", wait_val, rdata);
        apb_write(REG_FW_UPDATE_RESET, 32'h1, err);
        model_executed = 1'b1;
        wait_level(SIG_UC, 1'b0, TIMEOUT, "uc reset assertion", cycles);
        check_value("fw_update noncore high", 1, cptra_noncore_rst_b);
        check_value("fw_update window high", 1, fw_update_rst_window);
        cycles          = 0;
        noncore_dropped = 1'b0;
        while (!cptra_uc_rst_b) begin
            idle_cycles(1);
            cycles++;
            if (!cptra_noncore_rst_b) begin
                noncore_dropped = 1'b1;
            end
            if (cycles > int'(wait_val) + TIMEOUT) begin
                $display("Timeout: uc reset stayed low after the firmware update");
                abort_run();
            end
        end
        check_value("fw_update noncore dropped", 0, noncore_dropped);
        check_value("fw_update uc low long enough", 1, cycles >= int'(wait_val));
        check_value("fw_update window closed", 0, fw_update_rst_window);
        apb_read(REG_FW_UPDATE_RESET, rdata, err);
        check_value("fw_update request reads zero", 0, rdata);
        apb_read(REG_BOOT_STATUS, rdata, err);
        check_value("fw_update status", expected_status(BOOT_DONE, 1'b0, model_executed), rdata);

        // Warm reset keeps fuse_done but needs the done write again
        cptra_rst_b = 1'b0;
        idle_cycles(8);
        check_value("warm_reset noncore low", 0, cptra_noncore_rst_b);
        check_value("warm_reset uc low", 0, cptra_uc_rst_b);
        apb_read(REG_BOOT_STATUS, rdata, err);
        check_value("warm_reset idle status", expected_status(BOOT_IDLE, 1'b0, 1'b1), rdata);
        cptra_rst_b = 1'b1;
        wait_level(SIG_RDC, 1'b0, TIMEOUT, "rdc_clk_dis release", cycles);
        check_value("warm_reset rdc_clk_dis cycles", 3, cycles);
        idle_cycles(10);
        apb_read(REG_BOOT_STATUS, rdata, err);
        check_value("warm_reset held in FUSE", expected_status(BOOT_FUSE, 1'b1, 1'b1), rdata);
        apb_read(REG_FUSE_WR_DONE, rdata, err);
        check_value("warm_reset fuse_done kept", 1, rdata);
        apb_read(REG_FW_UPDATE_WAIT, rdata, err);
        check_value("warm_reset wait cleared", 0, rdata);
        apb_write(REG_FUSE_WR_DONE, 32'h1, err);
        wait_level(SIG_NONCORE, 1'b1, TIMEOUT, "noncore reset release", cycles);
        check_value("warm_reset noncore delay", 3, cycles);
        apb_read(REG_BOOT_STATUS, rdata, err);
        check_value("warm_reset status", expected_status(BOOT_DONE, 1'b0, 1'b1), rdata);

        // Error responses for holes in the map and the read-only status
        apb_read(12'h200, rdata, err);
        check_value("unmapped read pslverr", 1, err);
        apb_read(REG_FUSE_BASE + apb_addr_t'(4 * FUSE_WORDS), rdata, err);
        check_value("fuse range end pslverr", 1, err);
        apb_write(REG_BOOT_STATUS, 32'h0, err);
        check_value("status write pslverr", 1, err);
        apb_read(REG_BOOT_STATUS, rdata, err);
        check_value("status read pslverr", 0, err);
        check_value("status after write", expected_status(BOOT_DONE, 1'b0, 1'b1), rdata);

        if (error_count == 0) begin
            $display("all tests passed");
            $finish;
        end else begin
            abort_run();
        end
    end

endmodule

//--- list.f
design/soc_ifc_pkg.sv
design/boot_ctrl_if.sv
design/soc_ifc_boot_fsm.sv
design/soc_ifc_apb_regs.sv
design/soc_ifc_top.sv
verif/soc_ifc_tb_clk.sv
verif/soc_ifc_tb.sv
